//--- Bender.yml
package:
  name: rv_decode

sources:
  - hdl/rvDecodePkg.sv
  - hdl/operandDecode.sv
  - hdl/controlDecode.sv
  - hdl/decodeStage.sv
  - hdl/decodeTop.sv
  - target: test
    files:
      - test/decodeTb.sv

//--- hdl/controlDecode.sv
`timescale 1ns/100ps

module controlDecode (
    input  logic [rvDecodePkg::XLEN-1:0] instruction,
    output rvDecodePkg::aluOpT           aluOp,
    output logic                         selA, // 0 rs1, 1 pc
    output rvDecodePkg::selBT            selB,
    output logic                         aluToReg,
    output rvDecodePkg::memOpT           memOp,
    output rvDecodePkg::memSizeT         memSize,
    output logic                         branch,
    output logic                         jal,
    output logic                         jalr,
    output logic                         legal
);
    import rvDecodePkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign alt    = instruction[30];

    // Shared by register and immediate ALU instructions
    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic useAlt);
        aluOpT op;
        op = ADD;
        case (f3)
            F3_ADD_SUB: op = useAlt ? SUB : ADD;
            F3_SLL:     op = SLL;
            F3_SLT:     op = SLT;
            F3_SLTU:    op = SLTU;
            F3_XOR:     op = XOR;
            F3_SR:      op = useAlt ? SRA : SRL;
            F3_OR:      op = OR;
            F3_AND:     op = AND;
            default:    op = ADD;
        endcase
        return op;
    endfunction

    function automatic memSizeT sizeFromFunct3(input logic [1:0] f3Low);
        memSizeT size;
        case (f3Low)
            2'b00:   size = BYTE;
            2'b01:   size = HALFWORD;
            default: size = WORD;
        endcase
        return size;
    endfunction

    always_comb begin
        aluOp    = ADD;
        selA     = 1'b0;
        selB     = SEL_B_RS2;
        aluToReg = 1'b0;
        memOp    = MEM_DISABLE;
        memSize  = BYTE;
        branch   = 1'b0;
        jal      = 1'b0;
        jalr     = 1'b0;
        legal    = 1'b0;

        case (opcode)
            OP_R_TYPE: begin
                // ALT funct7 only exists for SUB and SRA
                legal    = (funct7 == 7'b0) ||
                           (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
                aluOp    = aluFromFunct3(funct3, alt);
                aluToReg = 1'b1;
            end
            OP_I_TYPE: begin
                case (funct3)
                    F3_SLL:  legal = (funct7 == 7'b0);
                    F3_SR:   legal = (funct7 == 7'b0) || (funct7 == F7_ALT);
                    default: legal = 1'b1;
                endcase
                // Bit 30 is immediate data except on right shifts
                aluOp    = aluFromFunct3(funct3, funct3 == F3_SR && alt);
                selB     = SEL_B_IMM;
                aluToReg = 1'b1;
            end
            OP_LOAD: begin
                legal   = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
                selB    = SEL_B_IMM; // Address is rs1 + imm
                memOp   = funct3[2] ? MEM_READ_ZEXT : MEM_READ_SEXT;
                memSize = sizeFromFunct3(funct3[1:0]);
            end
            OP_STORE: begin
                legal   = !funct3[2] && (funct3[1:0] != 2'b11);
                selB    = SEL_B_IMM;
                memOp   = MEM_WRITE;
                memSize = sizeFromFunct3(funct3[1:0]);
            end
            OP_BRANCH: begin
                legal  = 1'b1;
                branch = 1'b1;
                case (funct3)
                    3'b000:  aluOp = BEQ;
                    3'b001:  aluOp = BNE;
                    3'b100:  aluOp = BLT;
                    3'b101:  aluOp = BGE;
                    3'b110:  aluOp = BLTU;
                    3'b111:  aluOp = BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OP_JAL: begin
                legal    = 1'b1;
                selA     = 1'b1; // ALU computes pc + 4 for rd
                selB     = SEL_B_FOUR;
                aluToReg = 1'b1;
                jal      = 1'b1;
            end
            OP_JALR: begin
                legal    = (funct3 == 3'b000);
                selA     = 1'b1;
                selB     = SEL_B_FOUR;
                aluToReg = 1'b1;
                jalr     = 1'b1;
            end
            OP_LUI: begin
                legal    = 1'b1;
                selB     = SEL_B_IMM;
                aluToReg = 1'b1;
            end
            OP_AUIPC: begin
                legal    = 1'b1;
                selA     = 1'b1;
                selB     = SEL_B_IMM;
                aluToReg = 1'b1;
            end
            default: legal = 1'b0; // FENCE, SYSTEM and unknown opcodes
        endcase
    end

    // Redirect kinds are exclusive for any accepted word
    legalOneRedirect: assert property (@(instruction)
        legal |-> $onehot0({branch, jal, jalr}))
        else $error("controlDecode: more than one of branch/jal/jalr set");

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               stall,
    input  logic                               flush,
    input  logic [rvDecodePkg::XLEN-1:0]       pcIn,
    input  logic [rvDecodePkg::REG_ADDR_W-1:0] rs1Next,
    input  logic [rvDecodePkg::REG_ADDR_W-1:0] rs2Next,
    input  logic [rvDecodePkg::REG_ADDR_W-1:0] rdNext,
    input  logic [rvDecodePkg::XLEN-1:0]       immNext,
    input  rvDecodePkg::aluOpT                 aluOpNext,
    input  logic                               selANext,
    input  rvDecodePkg::selBT                  selBNext,
    input  logic                               aluToRegNext,
    input  rvDecodePkg::memOpT                 memOpNext,
    input  rvDecodePkg::memSizeT               memSizeNext,
    input  logic                               branchNext,
    input  logic                               jalNext,
    input  logic                               jalrNext,
    input  logic                               legal,
    output logic [rvDecodePkg::REG_ADDR_W-1:0] rs1,
    output logic [rvDecodePkg::REG_ADDR_W-1:0] rs2,
    output logic [rvDecodePkg::REG_ADDR_W-1:0] rd,
    output logic [rvDecodePkg::XLEN-1:0]       imm,
    output rvDecodePkg::aluOpT                 aluOp,
    output logic                               selA,
    output rvDecodePkg::selBT                  selB,
    output logic                               aluToReg,
    output rvDecodePkg::memOpT                 memOp,
    output rvDecodePkg::memSizeT               memSize,
    output logic                               branch,
    output logic                               jal,
    output logic                               jalr,
    output logic [rvDecodePkg::XLEN-1:0]       pc
);
    import rvDecodePkg::*;

    logic discard; // Set by flush, eats the next accepted word

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rs1      <= '0;
            rs2      <= '0;
            rd       <= '0;
            imm      <= '0;
            aluOp    <= ADD;
            selA     <= 1'b0;
            selB     <= SEL_B_RS2;
            aluToReg <= 1'b0;
            memOp    <= MEM_DISABLE;
            memSize  <= BYTE;
            branch   <= 1'b0;
            jal      <= 1'b0;
            jalr     <= 1'b0;
            pc       <= '0;
            discard  <= flush && !rst;
        end else if (!stall) begin
            if (discard) begin
                discard <= 1'b0; // Outputs stay cleared
            end else begin
                // Illegal words become a bubble that still carries pc
                rs1      <= legal ? rs1Next : '0;
                rs2      <= legal ? rs2Next : '0;
                rd       <= legal ? rdNext : '0;
                imm      <= legal ? immNext : '0;
                aluOp    <= legal ? aluOpNext : ADD;
                selA     <= legal && selANext;
                selB     <= legal ? selBNext : SEL_B_RS2;
                aluToReg <= legal && aluToRegNext;
                memOp    <= legal ? memOpNext : MEM_DISABLE;
                memSize  <= legal ? memSizeNext : BYTE;
                branch   <= legal && branchNext;
                jal      <= legal && jalNext;
                jalr     <= legal && jalrNext;
                pc       <= pcIn;
            end
        end
    end

    // Stores never name a destination, checked across both decoders
    storeNoRd: assert property (@(posedge clk) disable iff (rst)
        memOp == MEM_WRITE |-> rd == '0)
        else $error("decodeStage: store with nonzero rd");

    resetIdle: assert property (@(posedge clk)
        rst |=> !branch && !jal && !jalr && !aluToReg && memOp == MEM_DISABLE)
        else $error("decodeStage: control active after reset");

    stallHold: assert property (@(posedge clk)
        stall && !rst && !flush |=>
            $stable({rs1, rs2, rd, imm, aluOp, selA, selB, aluToReg,
                     memOp, memSize, branch, jal, jalr, pc}))
        else $error("decodeStage: outputs changed during stall");

endmodule

//--- hdl/decodeTop.sv
`timescale 1ns/100ps

module decodeTop (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               stall,
    input  logic                               flush,
    input  logic [rvDecodePkg::XLEN-1:0]       instruction,
    input  logic [rvDecodePkg::XLEN-1:0]       pcIn,
    output logic [rvDecodePkg::REG_ADDR_W-1:0] rs1,
    output logic [rvDecodePkg::REG_ADDR_W-1:0] rs2,
    output logic [rvDecodePkg::REG_ADDR_W-1:0] rd,
    output logic [rvDecodePkg::XLEN-1:0]       imm,
    output rvDecodePkg::aluOpT                 aluOp,
    output logic                               selA,
    output rvDecodePkg::selBT                  selB,
    output logic                               aluToReg,
    output rvDecodePkg::memOpT                 memOp,
    output rvDecodePkg::memSizeT               memSize,
    output logic                               branch,
    output logic                               jal,
    output logic                               jalr,
    output logic [rvDecodePkg::XLEN-1:0]       pc
);
    import rvDecodePkg::*;

    // Combinational decode results ahead of the stage register
    logic [REG_ADDR_W-1:0] rs1Next;
    logic [REG_ADDR_W-1:0] rs2Next;
    logic [REG_ADDR_W-1:0] rdNext;
    logic [XLEN-1:0]       immNext;
    aluOpT                 aluOpNext;
    logic                  selANext;
    selBT                  selBNext;
    logic                  aluToRegNext;
    memOpT                 memOpNext;
    memSizeT               memSizeNext;
    logic                  branchNext;
    logic                  jalNext;
    logic                  jalrNext;
    logic                  legal;

    operandDecode operands (
        .instruction (instruction),
        .rs1         (rs1Next),
        .rs2         (rs2Next),
        .rd          (rdNext),
        .imm         (immNext)
    );

    controlDecode control (
        .instruction (instruction),
        .aluOp       (aluOpNext),
        .selA        (selANext),
        .selB        (selBNext),
        .aluToReg    (aluToRegNext),
        .memOp       (memOpNext),
        .memSize     (memSizeNext),
        .branch      (branchNext),
        .jal         (jalNext),
        .jalr        (jalrNext),
        .legal       (legal)
    );

    decodeStage stage (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .pcIn         (pcIn),
        .rs1Next      (rs1Next),
        .rs2Next      (rs2Next),
        .rdNext       (rdNext),
        .immNext      (immNext),
        .aluOpNext    (aluOpNext),
        .selANext     (selANext),
        .selBNext     (selBNext),
        .aluToRegNext (aluToRegNext),
        .memOpNext    (memOpNext),
        .memSizeNext  (memSizeNext),
        .branchNext   (branchNext),
        .jalNext      (jalNext),
        .jalrNext     (jalrNext),
        .legal        (legal),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .aluOp        (aluOp),
        .selA         (selA),
        .selB         (selB),
        .aluToReg     (aluToReg),
        .memOp        (memOp),
        .memSize      (memSize),
        .branch       (branch),
        .jal          (jal),
        .jalr         (jalr),
        .pc           (pc)
    );

endmodule

//--- hdl/operandDecode.sv
`timescale 1ns/100ps

module operandDecode (
    input  logic [rvDecodePkg::XLEN-1:0]       instruction,
    output logic [rvDecodePkg::REG_ADDR_W-1:0] rs1,
    output logic [rvDecodePkg::REG_ADDR_W-1:0] rs2,
    output logic [rvDecodePkg::REG_ADDR_W-1:0] rd,
    output logic [rvDecodePkg::XLEN-1:0]       imm
);
    import rvDecodePkg::*;

    // Instruction formats as seen by the operand fields
    typedef enum logic [2:0] {
        FMT_NONE,
        FMT_R,
        FMT_I,
        FMT_SHIFT, // I-type with shamt
        FMT_S,
        FMT_B,
        FMT_J,
        FMT_U
    } formatT;

    formatT          format;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immJ;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immShamt;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];

    // All immediates sign-extend from bit 31
    assign immI = {{(XLEN-12){instruction[31]}}, instruction[31:20]};
    assign immS = {{(XLEN-12){instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{(XLEN-12){instruction[31]}}, instruction[7], instruction[30:25],
                   instruction[11:8], 1'b0};
    assign immJ = {{(XLEN-20){instruction[31]}}, instruction[19:12], instruction[20],
                   instruction[30:21], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immShamt = {{(XLEN-5){1'b0}}, instruction[24:20]};

    always_comb begin
        format = FMT_NONE;
        case (opcode)
            OP_R_TYPE: format = FMT_R;
            OP_I_TYPE: format = (funct3 == F3_SLL || funct3 == F3_SR) ? FMT_SHIFT : FMT_I;
            OP_LOAD:   format = FMT_I;
            OP_JALR:   format = FMT_I; // rs1 + I immediate
            OP_STORE:  format = FMT_S;
            OP_BRANCH: format = FMT_B;
            OP_JAL:    format = FMT_J;
            OP_LUI:    format = FMT_U;
            OP_AUIPC:  format = FMT_U;
            default:   format = FMT_NONE;
        endcase
    end

    // Fields a format does not use stay zero
    always_comb begin
        rs1 = '0;
        rs2 = '0;
        rd  = '0;
        imm = '0;
        case (format)
            FMT_R: begin
                rs1 = instruction[19:15];
                rs2 = instruction[24:20];
                rd  = instruction[11:7];
            end
            FMT_I: begin
                rs1 = instruction[19:15];
                rd  = instruction[11:7];
                imm = immI;
            end
            FMT_SHIFT: begin
                rs1 = instruction[19:15];
                rd  = instruction[11:7];
                imm = immShamt;
            end
            FMT_S: begin
                rs1 = instruction[19:15];
                rs2 = instruction[24:20];
                imm = immS;
            end
            FMT_B: begin
                rs1 = instruction[19:15];
                rs2 = instruction[24:20];
                imm = immB;
            end
            FMT_J: begin
                rd  = instruction[11:7];
                imm = immJ;
            end
            FMT_U: begin
                rd  = instruction[11:7];
                imm = immU;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/rvDecodePkg.sv
package rvDecodePkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes, RV32I
    localparam logic [6:0] OP_R_TYPE = 7'b0110011;
    localparam logic [6:0] OP_I_TYPE = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    // funct3 of the ALU group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB, SRA, SRAI

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9,
        BEQ  = 4'd10, // Compare ops used by the branch unit
        BNE  = 4'd11,
        BLT  = 4'd12,
        BGE  = 4'd13,
        BLTU = 4'd14,
        BGEU = 4'd15
    } aluOpT;

    typedef enum logic [1:0] {
        MEM_DISABLE   = 2'd0,
        MEM_READ_SEXT = 2'd1,
        MEM_READ_ZEXT = 2'd2,
        MEM_WRITE     = 2'd3
    } memOpT;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE     = 2'd0,
        HALFWORD = 2'd1,
        WORD     = 2'd2
    } memSizeT;

    // Second ALU operand
    typedef enum logic [1:0] {
        SEL_B_RS2  = 2'd0,
        SEL_B_IMM  = 2'd1,
        SEL_B_FOUR = 2'd2 // Link address pc + 4
    } selBT;

endpackage

//--- sim.f
hdl/rvDecodePkg.sv
hdl/operandDecode.sv
hdl/controlDecode.sv
hdl/decodeStage.sv
hdl/decodeTop.sv
test/decodeTb.sv

//--- test/decodeTb.sv
`timescale 1ns/100ps

module decodeTb;
    import rvDecodePkg::*;

    // Expected control word {aluOp, selA, selB, aluToReg, memOp, memSize, branch, jal, jalr}
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pcIn;
        logic        stall;
        logic        flush;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [14:0] ctrl;
        logic [31:0] pc;
    } entryT;

    logic        clk = 1'b0;
    logic        rst;
    logic        stall;
    logic        flush;
    logic [31:0] instruction;
    logic [31:0] pcIn;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    aluOpT       aluOp;
    logic        selA;
    selBT        selB;
    logic        aluToReg;
    memOpT       memOp;
    memSizeT     memSize;
    logic        branch;
    logic        jal;
    logic        jalr;
    logic [31:0] pc;

    entryT entries[$];
    int    entryIndex = -1; // -1 while checking reset
    int    cycleCount = 0;
    int    cycleLimit;

    decodeTop uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // Instruction encoders for the stimulus
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] r2,
                                         input logic [4:0] r1, input logic [2:0] f3,
                                         input logic [4:0] d);
        return {f7, r2, r1, f3, d, OP_R_TYPE};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] i, input logic [4:0] r1,
                                         input logic [2:0] f3, input logic [4:0] d,
                                         input logic [6:0] op);
        return {i, r1, f3, d, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] i, input logic [4:0] r2,
                                         input logic [4:0] r1, input logic [2:0] f3);
        return {i[11:5], r2, r1, f3, i[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] i, input logic [4:0] r2,
                                         input logic [4:0] r1, input logic [2:0] f3);
        return {i[12], i[10:5], r2, r1, f3, i[4:1], i[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] i, input logic [4:0] d);
        return {i[20], i[10:1], i[11], i[19:12], d, OP_JAL};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] i, input logic [4:0] d,
                                         input logic [6:0] op);
        return {i, d, op};
    endfunction

    function automatic logic [14:0] ctl(input logic [3:0] op, input logic a,
                                        input logic [1:0] b, input logic toReg,
                                        input logic [1:0] mop, input logic [1:0] msz,
                                        input logic [2:0] flow);
        return {op, a, b, toReg, mop, msz, flow};
    endfunction

    function automatic logic [14:0] aluCtl(input logic [3:0] op, input logic [1:0] b);
        return ctl(op, 1'b0, b, 1'b1, MEM_DISABLE, BYTE, 3'b000);
    endfunction

    function automatic logic [14:0] memCtl(input logic [1:0] mop, input logic [1:0] msz);
        return ctl(ADD, 1'b0, SEL_B_IMM, 1'b0, mop, msz, 3'b000);
    endfunction

    function automatic logic [14:0] branchCtl(input logic [3:0] op);
        return ctl(op, 1'b0, SEL_B_RS2, 1'b0, MEM_DISABLE, BYTE, 3'b100);
    endfunction

    function automatic logic [31:0] nextPc();
        return 32'h0000_1000 + 4 * entries.size();
    endfunction

    // Normal entry with pc taken from pcIn
    task automatic addEntry(input logic [31:0] instr, input logic [4:0] r1, input logic [4:0] r2,
                            input logic [4:0] d, input logic [31:0] i, input logic [14:0] c);
        entryT e;
        e = '0;
        e.instr = instr;
        e.pcIn  = nextPc();
        e.rs1   = r1;
        e.rs2   = r2;
        e.rd    = d;
        e.imm   = i;
        e.ctrl  = c;
        e.pc    = e.pcIn;
        entries.push_back(e);
    endtask

    task automatic addHold(input logic [31:0] instr);
        entryT e;
        e = entries[$]; // Stalled edge keeps the previous result
        e.instr = instr;
        e.pcIn  = nextPc();
        e.stall = 1'b1;
        e.flush = 1'b0;
        entries.push_back(e);
    endtask

    task automatic addFlush(input logic [31:0] instr, input logic st);
        entryT e;
        e = '0;
        e.instr = instr;
        e.pcIn  = nextPc();
        e.stall = st;
        e.flush = 1'b1;
        entries.push_back(e);
    endtask

    task automatic addDiscarded(input logic [31:0] instr);
        entryT e;
        e = '0;
        e.instr = instr;
        e.pcIn  = nextPc();
        entries.push_back(e);
    endtask

    task automatic buildTable();
        logic [31:0] r;
        // Register and immediate ALU group
        addEntry(encR(7'h00, 5'd3, 5'd2, F3_ADD_SUB, 5'd1), 2, 3, 1, 0, aluCtl(ADD, SEL_B_RS2));
        addEntry(encR(F7_ALT, 5'd6, 5'd5, F3_ADD_SUB, 5'd4), 5, 6, 4, 0, aluCtl(SUB, SEL_B_RS2));
        addEntry(encR(7'h00, 5'd9, 5'd8, F3_SLL, 5'd7), 8, 9, 7, 0, aluCtl(SLL, SEL_B_RS2));
        addEntry(encR(7'h00, 5'd12, 5'd11, F3_SLT, 5'd10), 11, 12, 10, 0, aluCtl(SLT, SEL_B_RS2));
        addEntry(encR(7'h00, 5'd15, 5'd14, F3_SLTU, 5'd13), 14, 15, 13, 0,
                 aluCtl(SLTU, SEL_B_RS2));
        addEntry(encR(7'h00, 5'd18, 5'd17, F3_XOR, 5'd16), 17, 18, 16, 0, aluCtl(XOR, SEL_B_RS2));
        addEntry(encR(7'h00, 5'd21, 5'd20, F3_SR, 5'd19), 20, 21, 19, 0, aluCtl(SRL, SEL_B_RS2));
        addEntry(encR(F7_ALT, 5'd24, 5'd23, F3_SR, 5'd22), 23, 24, 22, 0, aluCtl(SRA, SEL_B_RS2));
        addEntry(encR(7'h00, 5'd27, 5'd26, F3_OR, 5'd25), 26, 27, 25, 0, aluCtl(OR, SEL_B_RS2));
        addEntry(encR(7'h00, 5'd31, 5'd30, F3_AND, 5'd29), 30, 31, 29, 0, aluCtl(AND, SEL_B_RS2));
        addEntry(encI(12'hfff, 5'd2, F3_ADD_SUB, 5'd1, OP_I_TYPE), 2, 0, 1, 32'hffff_ffff,
                 aluCtl(ADD, SEL_B_IMM));
        addEntry(encI(12'h400, 5'd4, F3_ADD_SUB, 5'd3, OP_I_TYPE), 4, 0, 3, 32'h0000_0400,
                 aluCtl(ADD, SEL_B_IMM)); // Bit 30 set but still ADDI
        addEntry(encI(12'h800, 5'd6, F3_SLT, 5'd5, OP_I_TYPE), 6, 0, 5, 32'hffff_f800,
                 aluCtl(SLT, SEL_B_IMM));
        addEntry(encI(12'h7ff, 5'd8, F3_SLTU, 5'd7, OP_I_TYPE), 8, 0, 7, 32'h0000_07ff,
                 aluCtl(SLTU, SEL_B_IMM));
        addEntry(encI(12'h555, 5'd10, F3_XOR, 5'd9, OP_I_TYPE), 10, 0, 9, 32'h0000_0555,
                 aluCtl(XOR, SEL_B_IMM));
        addEntry(encI(12'haaa, 5'd12, F3_OR, 5'd11, OP_I_TYPE), 12, 0, 11, 32'hffff_faaa,
                 aluCtl(OR, SEL_B_IMM));
        addEntry(encI(12'h0f0, 5'd14, F3_AND, 5'd13, OP_I_TYPE), 14, 0, 13, 32'h0000_00f0,
                 aluCtl(AND, SEL_B_IMM));
        addEntry(encI({7'h00, 5'd31}, 5'd16, F3_SLL, 5'd15, OP_I_TYPE), 16, 0, 15, 32'h1f,
                 aluCtl(SLL, SEL_B_IMM));
        addEntry(encI({7'h00, 5'd1}, 5'd18, F3_SR, 5'd17, OP_I_TYPE), 18, 0, 17, 32'h1,
                 aluCtl(SRL, SEL_B_IMM));
        addEntry(encI({F7_ALT, 5'd7}, 5'd20, F3_SR, 5'd19, OP_I_TYPE), 20, 0, 19, 32'h7,
                 aluCtl(SRA, SEL_B_IMM)); // Imm holds only the shamt
        // Loads and stores
        addEntry(encI(12'hff8, 5'd6, 3'b000, 5'd5, OP_LOAD), 6, 0, 5, 32'hffff_fff8,
                 memCtl(MEM_READ_SEXT, BYTE));
        addEntry(encI(12'h010, 5'd6, 3'b001, 5'd5, OP_LOAD), 6, 0, 5, 32'h10,
                 memCtl(MEM_READ_SEXT, HALFWORD));
        addEntry(encI(12'h7fc, 5'd6, 3'b010, 5'd5, OP_LOAD), 6, 0, 5, 32'h7fc,
                 memCtl(MEM_READ_SEXT, WORD));
        addEntry(encI(12'h001, 5'd6, 3'b100, 5'd5, OP_LOAD), 6, 0, 5, 32'h1,
                 memCtl(MEM_READ_ZEXT, BYTE));
        addEntry(encI(12'h802, 5'd6, 3'b101, 5'd5, OP_LOAD), 6, 0, 5, 32'hffff_f802,
                 memCtl(MEM_READ_ZEXT, HALFWORD));
        addEntry(encS(12'hfff, 5'd7, 5'd8, 3'b000), 8, 7, 0, 32'hffff_ffff,
                 memCtl(MEM_WRITE, BYTE));
        addEntry(encS(12'h123, 5'd9, 5'd10, 3'b001), 10, 9, 0, 32'h123,
                 memCtl(MEM_WRITE, HALFWORD));
        addEntry(encS(12'h81f, 5'd11, 5'd12, 3'b010), 12, 11, 0, 32'hffff_f81f,
                 memCtl(MEM_WRITE, WORD));
        // Branches, jumps and upper immediates
        addEntry(encB(13'h1ff0, 5'd2, 5'd1, 3'b000), 1, 2, 0, 32'hffff_fff0, branchCtl(BEQ));
        addEntry(encB(13'h0804, 5'd4, 5'd3, 3'b001), 3, 4, 0, 32'h0000_0804, branchCtl(BNE));
        addEntry(encB(13'h1000, 5'd6, 5'd5, 3'b100), 5, 6, 0, 32'hffff_f000, branchCtl(BLT));
        addEntry(encB(13'h07fe, 5'd8, 5'd7, 3'b101), 7, 8, 0, 32'h0000_07fe, branchCtl(BGE));
        addEntry(encB(13'h0002, 5'd10, 5'd9, 3'b110), 9, 10, 0, 32'h0000_0002, branchCtl(BLTU));
        addEntry(encB(13'h1ffe, 5'd12, 5'd11, 3'b111), 11, 12, 0, 32'hffff_fffe, branchCtl(BGEU));
        addEntry(encJ(21'h1ffffc, 5'd1), 0, 0, 1, 32'hffff_fffc,
                 ctl(ADD, 1'b1, SEL_B_FOUR, 1'b1, MEM_DISABLE, BYTE, 3'b010));
        addEntry(encJ(21'h0ff800, 5'd5), 0, 0, 5, 32'h000f_f800,
                 ctl(ADD, 1'b1, SEL_B_FOUR, 1'b1, MEM_DISABLE, BYTE, 3'b010));
        addEntry(encI(12'hffc, 5'd10, 3'b000, 5'd1, OP_JALR), 10, 0, 1, 32'hffff_fffc,
                 ctl(ADD, 1'b1, SEL_B_FOUR, 1'b1, MEM_DISABLE, BYTE, 3'b001));
        addEntry(encU(20'habcde, 5'd3, OP_LUI), 0, 0, 3, 32'habcd_e000, aluCtl(ADD, SEL_B_IMM));
        addEntry(encU(20'h00001, 5'd4, OP_AUIPC), 0, 0, 4, 32'h0000_1000,
                 ctl(ADD, 1'b1, SEL_B_IMM, 1'b1, MEM_DISABLE, BYTE, 3'b000));
        // Bubbles still carry pc
        addEntry(32'h0ff0_000f, 0, 0, 0, 0, 15'h0); // FENCE
        addEntry(32'h0000_0073, 0, 0, 0, 0, 15'h0); // ECALL
        addEntry(encI(12'h004, 5'd1, 3'b011, 5'd2, OP_LOAD), 0, 0, 0, 0, 15'h0);
        addEntry(encB(13'h0008, 5'd2, 5'd1, 3'b010), 0, 0, 0, 0, 15'h0);
        addEntry(encR(7'h01, 5'd3, 5'd2, F3_ADD_SUB, 5'd1), 0, 0, 0, 0, 15'h0); // MUL
        addEntry(encI({F7_ALT, 5'd3}, 5'd1, F3_SLL, 5'd2, OP_I_TYPE), 0, 0, 0, 0, 15'h0);
        addEntry(encS(12'h000, 5'd1, 5'd2, 3'b011), 0, 0, 0, 0, 15'h0); // SD
        // Stall and flush
        addEntry(encR(7'h00, 5'd7, 5'd6, F3_ADD_SUB, 5'd5), 6, 7, 5, 0, aluCtl(ADD, SEL_B_RS2));
        addHold(encR(F7_ALT, 5'd3, 5'd2, F3_ADD_SUB, 5'd1));
        addHold(encU(20'h12345, 5'd9, OP_LUI));
        addEntry(encR(7'h00, 5'd3, 5'd2, F3_XOR, 5'd1), 2, 3, 1, 0, aluCtl(XOR, SEL_B_RS2));
        addFlush(encI(12'h001, 5'd1, F3_ADD_SUB, 5'd1, OP_I_TYPE), 1'b0);
        addDiscarded(encI(12'h004, 5'd2, 3'b010, 5'd3, OP_LOAD));
        addEntry(encI(12'h00f, 5'd4, F3_OR, 5'd5, OP_I_TYPE), 4, 0, 5, 32'hf,
                 aluCtl(OR, SEL_B_IMM));
        addFlush(encR(7'h00, 5'd3, 5'd2, F3_ADD_SUB, 5'd1), 1'b1); // Flush beats stall
        addHold(encS(12'h008, 5'd3, 5'd4, 3'b010));
        addDiscarded(encS(12'h008, 5'd3, 5'd4, 3'b010));
        addEntry(encR(7'h00, 5'd3, 5'd2, F3_SLTU, 5'd1), 2, 3, 1, 0, aluCtl(SLTU, SEL_B_RS2));
        // Random register fields
        for (int i = 0; i < 4; i++) begin
            r = $urandom;
            if (i % 2 == 0)
                addEntry(encR(7'h00, r[9:5], r[4:0], F3_ADD_SUB, r[14:10]), r[4:0], r[9:5],
                         r[14:10], 0, aluCtl(ADD, SEL_B_RS2));
            else
                addEntry(encR(7'h00, r[9:5], r[4:0], F3_AND, r[14:10]), r[4:0], r[9:5],
                         r[14:10], 0, aluCtl(AND, SEL_B_RS2));
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s at entry %0d: got 0x%08h, expected 0x%08h",
                     name, entryIndex, actual, expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic checkEntry(input entryT e);
        checkValue("rs1", rs1, e.rs1);
        checkValue("rs2", rs2, e.rs2);
        checkValue("rd", rd, e.rd);
        checkValue("imm", imm, e.imm);
        checkValue("aluOp", aluOp, e.ctrl[14:11]);
        checkValue("selA", selA, e.ctrl[10]);
        checkValue("selB", selB, e.ctrl[9:8]);
        checkValue("aluToReg", aluToReg, e.ctrl[7]);
        checkValue("memOp", memOp, e.ctrl[6:5]);
        checkValue("memSize", memSize, e.ctrl[4:3]);
        checkValue("branch", branch, e.ctrl[2]);
        checkValue("jal", jal, e.ctrl[1]);
        checkValue("jalr", jalr, e.ctrl[0]);
        checkValue("pc", pc, e.pc);
    endtask

    initial begin
        entryT cur;
        entryT idle;
        rst         = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        instruction = 32'h0;
        pcIn        = 32'h0;
        void'($urandom(32'hfd1c_f737));
        buildTable();
        cycleLimit = entries.size() + 10;

        repeat (2) @(posedge clk);
        #5;
        idle = '0;
        checkEntry(idle); // Everything cleared by reset
        rst = 1'b0;

        for (int i = 0; i < entries.size(); i++) begin
            cur = entries[i];
            entryIndex  = i;
            instruction = cur.instr;
            pcIn        = cur.pcIn;
            stall       = cur.stall;
            flush       = cur.flush;
            @(posedge clk);
            #5;
            checkEntry(cur);
        end

        $display("All tests passed");
        $finish;
    end

endmodule
